//--- src.f
px_state_pkg.sv
px_bus_pkg.sv
px_sequencer.sv
px_strobe_timer.sv
px_bus_ctrl.sv
px_int_ctrl.sv
px_top.sv
tb_px.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing
TOP       ?= tb_px
FLIST     ?= src.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- tb_px.sv
`timescale 1ns/1ps

module tb_px
	import px_state_pkg::*;
	import px_bus_pkg::*;
();

	typedef struct {
		px_op_t      op;
		logic [15:0] addr;
		logic [15:0] data;
		logic        irq;	// Interrupt raised with this row
		logic [3:0]  lvl;
		logic [15:0] exp_rd;
		logic [15:0] exp_ic;
		logic        fault;	// Row ends in awaria
		logic        pe;	// Responder forces parity error
	} row_t;

	logic        got = 1'b0;
	logic        clo_;
	logic        start;
	px_cmd_t     cmd;
	logic        irq;
	logic [3:0]  irq_lvl;
	px_bus_rsp_t bus_rsp = '0;
	logic        cmd_ready;
	logic        done;
	logic [15:0] rd_data;
	logic [15:0] ic;
	logic        int_ack;
	logic        halted;
	logic        awaria;
	px_bus_req_t bus_req;

	logic [15:0] mem [256];	// Bus memory
	logic        pe_mode;
	logic [31:0] lfsr = 32'h1e951af2;
	logic        serving;	// Request picked up
	logic        answered;
	logic [1:0]  delay;	// Cycles left before the answer
	px_bus_req_t last_req;
	row_t        tbl[$];

	px_top i_dut (
		.got       (got),
		.clo_      (clo_),
		.start     (start),
		.cmd       (cmd),
		.irq       (irq),
		.irq_lvl   (irq_lvl),
		.bus_rsp   (bus_rsp),
		.cmd_ready (cmd_ready),
		.done      (done),
		.rd_data   (rd_data),
		.ic        (ic),
		.int_ack   (int_ack),
		.halted    (halted),
		.awaria    (awaria),
		.bus_req   (bus_req)
	);

	always #50 got = ~got;	// 100 ns period

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		lfsr_step = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};	// Taps 32 22 2 1
	endfunction

	function automatic logic [15:0] fill_word(input logic [15:0] a);
		fill_word = {a[7:0] ^ a[15:8] ^ 8'h5c, ~a[7:0]};
	endfunction

	function automatic logic [3:0] req_bits(input px_op_t o);
		case (o)
			op_rd:   req_bits = 4'b1000;
			op_wr:   req_bits = 4'b0100;
			op_in:   req_bits = 4'b0010;
			default: req_bits = 4'b0001;
		endcase
	endfunction

	task automatic answer_bus;
		px_bus_rsp_t r;
		r        = '0;
		answered = 1'b1;
		if (last_req.addr == 16'hff00) begin
			r.en = 1'b1;	// No memory here
		end else begin
			r.ok = 1'b1;
			if (last_req.rd) begin
				r.data = mem[last_req.addr[7:0]];
				r.pe   = pe_mode;
			end else if (last_req.in) begin
				r.data = last_req.addr ^ 16'ha5a5;	// Device word
			end else if (last_req.wr) begin
				mem[last_req.addr[7:0]] = last_req.data;
			end
		end
		bus_rsp <= r;
	endtask

	// Bus responder answering after 0 to 3 cycles
	always @(negedge got) begin
		bus_rsp <= '0;	// One-cycle answer
		if (!clo_) begin
			for (int i = 0; i < 256; i++) begin
				mem[i] = fill_word(16'(i));
			end
			serving  = 1'b0;
			answered = 1'b0;
		end else if (!(bus_req.rd | bus_req.wr | bus_req.in | bus_req.ou)) begin
			serving = 1'b0;
		end else if (!serving) begin
			serving  = 1'b1;
			last_req = bus_req;
			answered = (bus_req.addr == 16'hff01);	// Dead address that never answers
			lfsr     = lfsr_step(lfsr);
			delay[0] = lfsr[0];
			lfsr     = lfsr_step(lfsr);
			delay[1] = lfsr[0];
			if (!answered && delay == 2'd0) begin
				answer_bus();
			end
		end else if (!answered) begin
			delay = delay - 2'd1;
			if (delay == 2'd0) begin
				answer_bus();
			end
		end
	end

	task automatic check(input string name, input logic [31:0] act, input logic [31:0] exp);
		if (act !== exp) begin
			$display("ERR %0t %s got %h expected %h", $time, name, act, exp);
			$display("test failed");
			$fatal(1);
		end
	endtask

	// Waits on done, int_ack, awaria, cmd_ready or halted
	task automatic wait_event(input int which, input string what);
		int   n;
		logic seen;
		n    = 0;
		seen = 1'b0;
		while (!seen) begin
			@(negedge got);
			case (which)
				0:       seen = done;
				1:       seen = int_ack;
				2:       seen = awaria;
				3:       seen = cmd_ready;
				default: seen = halted;
			endcase
			n++;
			if (!seen && n >= 500) begin
				$display("timeout, %s never came within 500 cycles", what);
				$display("test failed");
				$fatal(1);
			end
		end
	endtask

	task automatic apply_reset;
		clo_  = 1'b0;
		start = 1'b0;
		irq   = 1'b0;
		repeat (16) @(negedge got);
		clo_ = 1'b1;
		@(negedge got);
	endtask

	task automatic issue_cmd(input row_t r);
		wait_event(3, "cmd_ready");
		cmd.op   = r.op;
		cmd.addr = r.addr;
		cmd.data = r.data;
		start    = 1'b1;
		@(negedge got);
		start = 1'b0;
	endtask

	// Serves one interrupt and checks stack word and vector
	task automatic take_int(input logic [3:0] lvl, input logic [15:0] old_ic);
		wait_event(1, "int_ack");
		check("halted", 32'(halted), 32'd0);
		irq = 1'b0;
		@(negedge got);
		check("int_ack", 32'(int_ack), 32'd0);	// Single pulse
		check("ic", 32'(ic), 32'(fill_word(vec_base + 16'(lvl))));
		check("stack word", 32'(mem[stack_addr[7:0]]), 32'(old_ic));
	endtask

	task automatic add_row(input px_op_t op, input logic [15:0] addr, input logic [15:0] data,
			input logic irq_on, input logic [3:0] lvl, input logic [15:0] exp_rd,
			input logic [15:0] exp_ic, input logic fault, input logic pe);
		row_t r;
		r.op     = op;
		r.addr   = addr;
		r.data   = data;
		r.irq    = irq_on;
		r.lvl    = lvl;
		r.exp_rd = exp_rd;
		r.exp_ic = exp_ic;
		r.fault  = fault;
		r.pe     = pe;
		tbl.push_back(r);
	endtask

	task automatic build_table;
		logic [15:0] v3;
		logic [15:0] v5;
		v3 = fill_word(16'h0043);	// Vector for level 3
		v5 = fill_word(16'h0045);
		add_row(op_wr, 16'h0010, 16'h1234, 0, 0, 0, 16'd1, 0, 0);
		add_row(op_rd, 16'h0010, 16'h0000, 0, 0, 16'h1234, 16'd2, 0, 0);
		add_row(op_in, 16'h0305, 16'h0000, 0, 0, 16'h0305 ^ 16'ha5a5, 16'd3, 0, 0);
		add_row(op_ou, 16'h0306, 16'hbeef, 0, 0, 0, 16'd4, 0, 0);
		add_row(op_hlt, 16'h0000, 16'h0000, 1, 3, 0, v3, 0, 0);
		add_row(op_rd, 16'h0022, 16'h0000, 1, 5, fill_word(16'h0022), v5 + 16'd1, 0, 0);
		add_row(op_rd, 16'hff00, 16'h0000, 0, 0, 16'h0000, v5 + 16'd2, 0, 0);	// en
		add_row(op_wr, 16'hff00, 16'h5555, 0, 0, 0, v5 + 16'd3, 0, 0);
		add_row(op_rd, 16'h0030, 16'h0000, 0, 0, 0, 16'd0, 1, 1);	// Parity fault
		add_row(op_wr, 16'hff01, 16'h7777, 0, 0, 0, 16'd0, 1, 0);	// Bus timeout
	endtask

	task automatic run_row(input row_t r);
		logic [15:0] prev_ic;
		if (r.fault) begin
			apply_reset();
		end
		prev_ic = ic;
		if (r.irq && r.op != op_hlt) begin
			wait_event(3, "cmd_ready");
			cmd.op   = r.op;
			cmd.addr = r.addr;
			cmd.data = r.data;
			start    = 1'b1;
			irq      = 1'b1;
			irq_lvl  = r.lvl;
			@(negedge got);
			start = 1'b0;
			check("cmd_ready", 32'(cmd_ready), 32'd0);	// Start lost to irq
			take_int(r.lvl, prev_ic);
		end
		pe_mode = r.pe;
		issue_cmd(r);
		if (r.op == op_hlt) begin
			wait_event(4, "halted");
			repeat (4) begin
				@(negedge got);
				check("halted", 32'(halted), 32'd1);
			end
			irq     = 1'b1;
			irq_lvl = r.lvl;
			take_int(r.lvl, prev_ic);
		end else if (r.fault) begin
			wait_event(2, "awaria");
			pe_mode = 1'b0;
			repeat (8) begin
				@(negedge got);
				check("bus_req bits", 32'({bus_req.rd, bus_req.wr, bus_req.in, bus_req.ou}),
					32'd0);
				check("bus_req addr data", 32'({bus_req.addr, bus_req.data}), 32'd0);
				check("cmd_ready", 32'(cmd_ready), 32'd0);
				check("awaria", 32'(awaria), 32'd1);
			end
		end else begin
			wait_event(0, "done");
			if (r.op == op_rd || r.op == op_in) begin
				check("rd_data", 32'(rd_data), 32'(r.exp_rd));
			end
			check("bus_req bits", 32'({last_req.rd, last_req.wr, last_req.in, last_req.ou}),
				32'(req_bits(r.op)));
			check("bus_req addr", 32'(last_req.addr), 32'(r.addr));
			if (r.op == op_wr || r.op == op_ou) begin
				check("bus_req data", 32'(last_req.data), 32'(r.data));
			end
			@(negedge got);
			check("done", 32'(done), 32'd0);	// One-cycle pulse
			check("awaria", 32'(awaria), 32'd0);
		end
		check("ic", 32'(ic), 32'(r.exp_ic));
	endtask

	initial begin
		clo_    = 1'b0;
		start   = 1'b0;
		cmd     = '0;
		irq     = 1'b0;
		irq_lvl = 4'd0;
		pe_mode = 1'b0;
		build_table();
		apply_reset();
		check("cmd_ready", 32'(cmd_ready), 32'd1);
		check("bus_req bits", 32'({bus_req.rd, bus_req.wr, bus_req.in, bus_req.ou}), 32'd0);
		check("bus_req addr data", 32'({bus_req.addr, bus_req.data}), 32'd0);
		check("awaria", 32'(awaria), 32'd0);
		check("halted", 32'(halted), 32'd0);
		check("ic", 32'(ic), 32'd0);
		foreach (tbl[k]) begin
			run_row(tbl[k]);
		end
		$display("test passed");
		$finish;
	end

endmodule

//--- px_top.sv
`timescale 1ns/1ps

module px_top
	import px_state_pkg::*;
	import px_bus_pkg::*;
(
	input  logic                 got,
	input  logic                 clo_,
	input  logic                 start,
	input  px_cmd_t              cmd,	// Held by the host until done
	input  logic                 irq,
	input  logic [int_lvl_w-1:0] irq_lvl,
	input  px_bus_rsp_t          bus_rsp,
	output logic                 cmd_ready,
	output logic                 done,
	output logic [15:0]          rd_data,
	output logic [15:0]          ic,
	output logic                 int_ack,
	output logic                 halted,
	output logic                 awaria,
	output px_bus_req_t          bus_req
);

	px_state_t   state;	// Current cycle state
	logic        step;	// State advance
	logic        strob1;	// Request launch phase
	logic        alarm;	// Bus timeout
	logic        bus_busy;	// Waiting on the bus
	logic        bus_fault;	// Fault event
	logic        int_pend;	// Interrupt to serve
	logic [15:0] vec_addr;	// Vector word address

	px_sequencer u_seq (
		.got       (got),
		.clo_      (clo_),
		.start     (start),
		.cmd       (cmd),
		.step      (step),
		.int_pend  (int_pend),
		.bus_fault (bus_fault),
		.state     (state),
		.op        (),
		.cmd_ready (cmd_ready),
		.done      (done),
		.halted    (halted)
	);

	px_strobe_timer u_tim (
		.got      (got),
		.clo_     (clo_),
		.state    (state),
		.bus_busy (bus_busy),
		.strob1   (strob1),
		.strob2   (),
		.step     (step),
		.alarm    (alarm)
	);

	px_bus_ctrl u_bus (
		.got       (got),
		.clo_      (clo_),
		.state     (state),
		.strob1    (strob1),
		.alarm     (alarm),
		.addr      (cmd.addr),
		.wdata     (cmd.data),
		.ic        (ic),
		.vec_addr  (vec_addr),
		.bus_rsp   (bus_rsp),
		.bus_req   (bus_req),
		.bus_busy  (bus_busy),
		.rd_data   (rd_data),
		.bus_fault (bus_fault),
		.awaria    (awaria)
	);

	px_int_ctrl u_int (
		.got      (got),
		.clo_     (clo_),
		.irq      (irq),
		.irq_lvl  (irq_lvl),
		.state    (state),
		.step     (step),
		.rd_data  (rd_data),
		.int_pend (int_pend),
		.vec_addr (vec_addr),
		.ic       (ic),
		.int_ack  (int_ack)
	);

endmodule

//--- px_int_ctrl.sv
`timescale 1ns/1ps

module px_int_ctrl
	import px_state_pkg::*;
	import px_bus_pkg::*;
(
	input  logic                 got,
	input  logic                 clo_,
	input  logic                 irq,	// Held until int_ack
	input  logic [int_lvl_w-1:0] irq_lvl,
	input  px_state_t            state,
	input  logic                 step,
	input  logic [15:0]          rd_data,	// Vector from I2
	output logic                 int_pend,
	output logic [15:0]          vec_addr,
	output logic [15:0]          ic,	// Instruction counter
	output logic                 int_ack
);

	logic                 pend_q;	// Interrupt registered
	logic [int_lvl_w-1:0] lvl_q;	// Level of the taken interrupt
	logic                 int_kc;	// KC after I3
	logic                 can_take;	// States that look at irq

	assign can_take = (state == P0) | (state == WA);
	assign int_pend = pend_q | (irq & can_take);	// Seen in the same cycle as irq
	assign int_ack  = step & (state == I3);
	assign vec_addr = vec_base + 16'(lvl_q);

	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			pend_q <= 1'b0;
			lvl_q  <= '0;
		end else if (irq && can_take && !pend_q) begin
			pend_q <= 1'b1;
			lvl_q  <= irq_lvl;
		end else if (int_ack) begin
			pend_q <= 1'b0;	// Served
		end
	end

	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			ic     <= 16'h0000;
			int_kc <= 1'b0;
		end else if (int_ack) begin
			ic     <= rd_data;	// Jump to vector
			int_kc <= 1'b1;
		end else if (step && state == KC) begin
			if (!int_kc) begin
				ic <= ic + 16'h0001;	// One per finished command
			end
			int_kc <= 1'b0;
		end
	end

endmodule

//--- px_bus_ctrl.sv
`timescale 1ns/1ps

module px_bus_ctrl
	import px_state_pkg::*;
	import px_bus_pkg::*;
(
	input  logic        got,
	input  logic        clo_,
	input  px_state_t   state,
	input  logic        strob1,
	input  logic        alarm,
	input  logic [15:0] addr,	// Command address
	input  logic [15:0] wdata,	// Command write data
	input  logic [15:0] ic,	// Pushed in I1
	input  logic [15:0] vec_addr,	// Read in I2
	input  px_bus_rsp_t bus_rsp,
	output px_bus_req_t bus_req,
	output logic        bus_busy,
	output logic [15:0] rd_data,
	output logic        bus_fault,	// Fault event, one cycle
	output logic        awaria	// Sticky fault level
);

	px_bus_req_t req_nx;	// Request for the current state
	logic        is_bus;	// State runs a bus cycle
	logic        s1_q;	// strob1 one cycle back
	logic        s1_start;	// First cycle of a state
	logic        ans;	// Answer seen in this state
	logic        act;	// Request on the bus
	logic        answer;	// ok or en for our request
	logic        pe_fault;	// Bad parity on read

	always_comb begin
		req_nx = '0;
		is_bus = 1'b1;
		case (state)
			WR: begin
				req_nx.rd   = 1'b1;
				req_nx.addr = addr;
			end
			WW: begin
				req_nx.wr   = 1'b1;
				req_nx.addr = addr;
				req_nx.data = wdata;
			end
			WX: begin
				req_nx.in   = 1'b1;
				req_nx.addr = addr;
			end
			WM: begin
				req_nx.ou   = 1'b1;
				req_nx.addr = addr;
				req_nx.data = wdata;
			end
			I1: begin
				req_nx.wr   = 1'b1;	// Save ic on the stack word
				req_nx.addr = stack_addr;
				req_nx.data = ic;
			end
			I2: begin
				req_nx.rd   = 1'b1;	// Vector fetch
				req_nx.addr = vec_addr;
			end
			default: is_bus = 1'b0;
		endcase
	end

	assign s1_start  = strob1 & ~s1_q;	// strob1 rises once per state
	assign act       = |{bus_req.rd, bus_req.wr, bus_req.in, bus_req.ou};
	assign answer    = act & (bus_rsp.ok | bus_rsp.en);
	assign pe_fault  = act & bus_req.rd & bus_rsp.ok & bus_rsp.pe;
	assign bus_fault = alarm | pe_fault;
	assign bus_busy  = is_bus & ~awaria & (s1_start | ~ans);	// Stale ans ignored on entry

	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			bus_req <= '0;
			s1_q    <= 1'b0;
			ans     <= 1'b0;
			awaria  <= 1'b0;
		end else begin
			s1_q <= strob1;
			if (s1_start) begin
				ans <= 1'b0;
			end
			if (s1_start && is_bus && !awaria) begin
				bus_req <= req_nx;	// Held until answer or alarm
			end else if (answer || alarm) begin
				bus_req <= '0;
				ans     <= 1'b1;
			end
			if (bus_fault) begin
				awaria <= 1'b1;	// Only clo_ clears it
			end
		end
	end

	// Read word, zero when nobody answers with data
	always_ff @(posedge got) begin
		if (answer && (bus_req.rd || bus_req.in)) begin
			rd_data <= bus_rsp.ok ? bus_rsp.data : 16'h0000;
		end
	end

endmodule

//--- px_strobe_timer.sv
`timescale 1ns/1ps

module px_strobe_timer
	import px_state_pkg::*;
	import px_bus_pkg::*;
(
	input  logic      got,
	input  logic      clo_,
	input  px_state_t state,
	input  logic      bus_busy,	// Bus cycle not yet answered
	output logic      strob1,
	output logic      strob2,
	output logic      step,	// One-cycle state advance
	output logic      alarm	// Bus answer overdue
);

	logic [phase_w-1:0] cnt;	// Phase within the state
	logic [alarm_w-1:0] acnt;	// Cycles spent waiting on the bus
	logic               run;	// Timer active
	logic               hold;	// Parked before strob2

	assign run    = (state != AW);	// Stopped in fault stop
	assign hold   = bus_busy & (cnt == phase_w'(strob1_ticks));	// Waits for the answer
	assign strob1 = run & (cnt < phase_w'(strob1_ticks));
	assign strob2 = run & (cnt >= phase_w'(strob1_ticks)) & ~hold;
	assign step   = strob2 & (cnt == phase_w'(strob1_ticks + strob2_ticks - 1));	// Last strob2 tick
	assign alarm  = bus_busy & (acnt == alarm_w'(alarm_ticks - 1));

	// Restarts with every step so each state begins at phase zero
	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			cnt <= '0;
		end else if (!run || step) begin
			cnt <= '0;
		end else if (!hold) begin
			cnt <= cnt + 1'b1;
		end
	end

	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			acnt <= '0;
		end else if (!bus_busy) begin
			acnt <= '0;	// Cleared between bus cycles
		end else begin
			acnt <= acnt + 1'b1;
		end
	end

endmodule

//--- px_sequencer.sv
`timescale 1ns/1ps

module px_sequencer
	import px_state_pkg::*;
(
	input  logic      got,
	input  logic      clo_,
	input  logic      start,	// Command strobe
	input  px_cmd_t   cmd,	// Command, opcode taken at start
	input  logic      step,	// State advance from the timer
	input  logic      int_pend,	// Interrupt waiting
	input  logic      bus_fault,	// Alarm or parity fault this cycle
	output px_state_t state,
	output px_op_t    op,	// Latched opcode
	output logic      cmd_ready,
	output logic      done,	// Command finished
	output logic      halted
);

	px_state_t state_nx;	// Next cycle state
	logic      cmd_pend;	// Accepted command waiting for its step
	logic      int_cyc;	// KC belongs to an interrupt
	logic      accept;	// Command taken this cycle

	// Bus state for an opcode
	function automatic px_state_t op_state(input px_op_t o);
		case (o)
			op_rd:   op_state = WR;
			op_wr:   op_state = WW;
			op_in:   op_state = WX;
			op_ou:   op_state = WM;
			default: op_state = WA;	// op_hlt
		endcase
	endfunction

	assign cmd_ready = (state == P0) & ~int_pend & ~cmd_pend;	// Interrupt wins over start
	assign accept    = start & cmd_ready;
	assign halted    = (state == WA);
	assign done      = step & (state == KC) & ~int_cyc;	// Leaving KC of a command

	always_comb begin
		state_nx = state;
		if (bus_fault) begin
			state_nx = AW;	// Fault overrides the step
		end else if (step) begin
			case (state)
				P0: begin
					if (int_pend) begin
						state_nx = I1;
					end else if (cmd_pend) begin
						state_nx = op_state(op);
					end
				end
				WA: begin
					if (int_pend) begin
						state_nx = I1;	// Only an interrupt ends the halt
					end
				end
				WR, WW, WX, WM: state_nx = KC;
				I1:      state_nx = I2;
				I2:      state_nx = I3;
				I3:      state_nx = KC;
				KC:      state_nx = P0;
				default: state_nx = state;	// AW holds
			endcase
		end
	end

	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			state    <= P0;
			op       <= op_rd;
			cmd_pend <= 1'b0;
			int_cyc  <= 1'b0;
		end else begin
			state <= state_nx;
			if (accept) begin
				op       <= cmd.op;
				cmd_pend <= 1'b1;
			end else if (step && state == P0 && !int_pend) begin
				cmd_pend <= 1'b0;	// Command leaves P0
			end
			if (step && state == I3) begin
				int_cyc <= 1'b1;	// Next KC closes the interrupt
			end else if (step && state == KC) begin
				int_cyc <= 1'b0;
			end
		end
	end

endmodule

//--- px_bus_pkg.sv
package px_bus_pkg;

	// Strobe phase lengths in got cycles
	localparam int strob1_ticks = 2;	// strob1 at the start of every state
	localparam int strob2_ticks = 1;	// strob2 before the step
	localparam int alarm_ticks  = 64;	// Longest wait for a bus answer

	// Counter widths derived from the phase lengths
	localparam int phase_w = $clog2(strob1_ticks + strob2_ticks);	// Phase counter
	localparam int alarm_w = $clog2(alarm_ticks);	// Alarm counter

	// Fixed interrupt addresses
	localparam logic [15:0] stack_addr = 16'h0061;	// ic saved here in I1
	localparam logic [15:0] vec_base   = 16'h0040;	// Vector table base

	localparam int int_lvl_w = 4;	// Interrupt level width

	// Request toward the system bus
	typedef struct packed {
		logic        rd;	// Memory read
		logic        wr;	// Memory write
		logic        in;	// I/O input
		logic        ou;	// I/O output
		logic [15:0] addr;	// Address lines
		logic [15:0] data;	// Write data lines
	} px_bus_req_t;

	// Answer from the system bus, one cycle wide
	typedef struct packed {
		logic        ok;	// Accepted
		logic        en;	// No such memory or device
		logic        pe;	// Parity error on read data
		logic [15:0] data;	// Read data
	} px_bus_rsp_t;

endpackage

//--- px_state_pkg.sv
package px_state_pkg;

	// Cycle states of the control unit
	typedef enum logic [4:0] {
		P0 = 5'd0,	// Idle, waits for a command or an interrupt
		WR = 5'd1,	// Memory read bus cycle
		WW = 5'd2,	// Memory write bus cycle
		WX = 5'd3,	// I/O input bus cycle
		WM = 5'd4,	// I/O output bus cycle
		WA = 5'd5,	// Halt wait
		I1 = 5'd6,	// Interrupt phase 1, push ic
		I2 = 5'd7,	// Interrupt phase 2, fetch vector
		I3 = 5'd8,	// Interrupt phase 3, load ic
		KC = 5'd9,	// End of cycle
		AW = 5'd10	// Fault stop, left only by clo_
	} px_state_t;

	// Command opcodes
	typedef enum logic [2:0] {
		op_rd  = 3'd0,	// Memory read
		op_wr  = 3'd1,	// Memory write
		op_in  = 3'd2,	// I/O input
		op_ou  = 3'd3,	// I/O output
		op_hlt = 3'd4	// Halt until interrupt
	} px_op_t;

	// One command from the host
	typedef struct packed {
		px_op_t      op;	// What to do
		logic [15:0] addr;	// Memory or device address
		logic [15:0] data;	// Write data for op_wr and op_ou
	} px_cmd_t;

endpackage
